/* project.f */
+incdir+verilog
verilog/fetch_bus_pkg.sv
verilog/fetch_pipe_pkg.sv
verilog/pc_gen.sv
verilog/insn_fetch.sv
verilog/fetch_top.sv
sim/tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Compile the fetch front end with Verilator and run the testbench
# The run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module tb_fetch -f project.f -o tb_fetch_sim \
	&& ./obj_dir/tb_fetch_sim > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "Some tests failed" "$LOG" && { echo "Simulation FAILED"; exit 1; } \
	|| { echo "Simulation finished without failures"; exit 0; }

/* sim/tb_fetch.sv */
////////////////////////////////////////////////////////////
// Fetch front end testbench
// Instruction cache model, directed tests and a summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module tb_fetch
	import fetch_bus_pkg::*;
	import fetch_pipe_pkg::*;
();

	// Tests need about 90 cycles, limit leaves a wide margin
	localparam int MAX_CYCLES = 400;
	// Cache model answers one cycle after a new address
	localparam int RSP_WAIT   = 8;

	logic                 clk;
	logic                 arst_n;
	ic_rsp_t              ic_rsp;
	ic_req_t              ic_req;
	logic                 freeze;
	logic                 flushpipe;
	logic                 no_more_dslot;
	logic                 rfe;
	redirect_t            redirect;
	fetch_out_t           fetch_out;
	logic                 if_stall;
	logic                 saving_insn;

	// Cache model state
	logic [`FETCH_DW-1:0] mem [0:255];
	logic [`FETCH_AW-1:0] last_adr;
	logic [`FETCH_AW-1:0] pend_adr;
	logic                 pend;
	logic                 err_next;
	logic [3:0]           err_tag;

	integer               seed;
	int                   cycle_cnt = 0;
	int                   errors;
	int                   test_errors;
	int                   tests_passed;
	int                   tests_failed;
	string                cur_test;
	// Address of the next word expected from fetch
	logic [`FETCH_AW-1:0] exp_pc;

	fetch_top DUT (
		.clk             (clk),
		.arst_n_i        (arst_n),
		.ic_rsp_i        (ic_rsp),
		.ic_req_o        (ic_req),
		.freeze_i        (freeze),
		.flushpipe_i     (flushpipe),
		.no_more_dslot_i (no_more_dslot),
		.rfe_i           (rfe),
		.redirect_i      (redirect),
		.fetch_o         (fetch_out),
		.if_stall_o      (if_stall),
		.saving_insn_o   (saving_insn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic check(input string what, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (exp_val !== act_val) begin
			$display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
				cur_test, what, exp_val, act_val);
			errors++;
		end
	endtask

	// Flag order is itlbmiss, immufault, ibuserr
	function automatic logic [2:0] exc_for_tag(input logic [3:0] tag);
		case (tag)
			`FETCH_TAG_TE: return 3'b100;
			`FETCH_TAG_PE: return 3'b010;
			`FETCH_TAG_BE: return 3'b001;
			default:       return 3'b000;
		endcase
	endfunction

	// Cache model step, a new address gets its answer next cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (pend) begin
			ic_rsp.adr = pend_adr;
			ic_rsp.dat = mem[pend_adr[9:2]];
			ic_rsp.ack = !err_next;
			ic_rsp.err = err_next;
			ic_rsp.tag = err_next ? err_tag : 4'h0;
			pend       = 1'b0;
		end else begin
			ic_rsp = '0;
		end
		if (ic_req.adr != last_adr) begin
			pend     = 1'b1;
			pend_adr = ic_req.adr;
		end
		last_adr = ic_req.adr;
	endtask

	task automatic wait_rsp();
		int n;
		n = 0;
		next_cycle();
		while (!(ic_rsp.ack || ic_rsp.err) && n < RSP_WAIT) begin
			next_cycle();
			n++;
		end
		if (!(ic_rsp.ack || ic_rsp.err)) begin
			$display("%s: no cache response within %0d cycles", cur_test, RSP_WAIT);
			errors++;
		end
	endtask

	// One fetch, pipeline controls applied in the response cycle
	task automatic fetch_word(input logic use_err, input logic [3:0] tag,
			input logic frz, input logic dslot, input logic ret, input logic bubble);
		logic        kill;
		logic [31:0] exp_insn;
		logic [2:0]  exp_exc;
		err_next = use_err;
		err_tag  = tag;
		wait_rsp();
		err_next      = 1'b0;
		freeze        = frz;
		flushpipe     = 1'b0;
		no_more_dslot = dslot;
		rfe           = ret;
		kill     = dslot | ret;
		exp_insn = (kill || bubble || use_err) ? `FETCH_NOP_FLUSH : mem[exp_pc[9:2]];
		exp_exc  = (kill || !use_err) ? 3'b000 : exc_for_tag(tag);
		@(negedge clk);
		check("insn", exp_insn, fetch_out.insn);
		check("pc", exp_pc, fetch_out.pc);
		check("exc", {29'd0, exp_exc}, {29'd0, fetch_out.exc});
		check("if_stall", 32'd0, {31'd0, if_stall});
		check("saving", {31'd0, frz}, {31'd0, saving_insn});
		if (!frz)
			exp_pc = exp_pc + 32'd4;
	endtask

	// Replay of a saved word, then release and resume at the next word
	task automatic hold_release(input logic [31:0] exp_insn, input logic [2:0] exp_exc);
		repeat (2) begin
			next_cycle();
			@(negedge clk);
			check("held insn", exp_insn, fetch_out.insn);
			check("held pc", exp_pc, fetch_out.pc);
			check("held exc", {29'd0, exp_exc}, {29'd0, fetch_out.exc});
			check("held if_stall", 32'd0, {31'd0, if_stall});
			check("held saving", 32'd0, {31'd0, saving_insn});
		end
		next_cycle();
		freeze = 1'b0;
		@(negedge clk);
		check("released insn", exp_insn, fetch_out.insn);
		exp_pc = exp_pc + 32'd4;
		next_cycle();
		@(negedge clk);
		check("request after release", exp_pc, ic_req.adr);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// Strobe in a response cycle, target marked on the bus one cycle later
	task automatic redirect_to(input logic [31:0] target, input logic bubble);
		wait_rsp();
		redirect.valid  = 1'b1;
		redirect.target = target;
		@(negedge clk);
		check("insn at redirect", bubble ? `FETCH_NOP_FLUSH : mem[exp_pc[9:2]],
			fetch_out.insn);
		check("pc at redirect", exp_pc, fetch_out.pc);
		next_cycle();
		redirect.valid = 1'b0;
		@(negedge clk);
		check("redirect request", target | 32'd1, ic_req.adr);
		exp_pc = target;
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		if (errors == test_errors) begin
			$display("Test %s passed", cur_test);
			tests_passed++;
		end else begin
			$display("Test %s failed with %0d errors", cur_test, errors - test_errors);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_and_sequence();
		begin_test("reset_sequence");
		@(negedge clk);
		check("reset request", `FETCH_RESET_VECTOR, ic_req.adr);
		check("reset cyc", 32'd1, {31'd0, ic_req.cyc});
		check("reset exc", 32'd0, {29'd0, fetch_out.exc});
		check("reset if_stall", 32'd1, {31'd0, if_stall});
		exp_pc = `FETCH_RESET_VECTOR;
		repeat (4)
			fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		end_test();
	endtask

	task automatic freeze_replay();
		begin_test("freeze_replay");
		fetch_word(1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0);
		hold_release(mem[exp_pc[9:2]], 3'b000);
		end_test();
	endtask

	task automatic error_tags();
		logic [3:0] tag;
		begin_test("error_tags");
		for (int i = 0; i < 6; i++) begin
			tag = (i % 3 == 0) ? `FETCH_TAG_TE : (i % 3 == 1) ? `FETCH_TAG_PE : `FETCH_TAG_BE;
			// Second round captures the errored word under freeze
			fetch_word(1'b1, tag, i >= 3, 1'b0, 1'b0, 1'b0);
			if (i >= 3)
				hold_release(`FETCH_NOP_FLUSH, exc_for_tag(tag));
		end
		end_test();
	endtask

	task automatic flush_bypass();
		begin_test("flush_bypass");
		next_cycle();
		flushpipe = 1'b1;
		@(negedge clk);
		check("stall word", `FETCH_NOP_STALL, fetch_out.insn);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b1);
		redirect_to(32'h0000_0240, 1'b1);
		end_test();
	endtask

	task automatic redirect_load();
		begin_test("redirect_load");
		redirect_to(32'h0000_0080, 1'b0);
		end_test();
	endtask

	task automatic dslot_rfe_kill();
		begin_test("dslot_rfe_kill");
		fetch_word(1'b1, `FETCH_TAG_BE, 1'b0, 1'b1, 1'b0, 1'b0);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b1, 1'b0, 1'b0);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0);
		fetch_word(1'b1, `FETCH_TAG_TE, 1'b0, 1'b0, 1'b1, 1'b0);
		fetch_word(1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0);
		end_test();
	endtask

	initial begin
		arst_n        = 1'b0;
		ic_rsp        = '0;
		freeze        = 1'b0;
		flushpipe     = 1'b0;
		no_more_dslot = 1'b0;
		rfe           = 1'b0;
		redirect      = '0;
		pend          = 1'b0;
		pend_adr      = '0;
		last_adr      = '1;
		err_next      = 1'b0;
		err_tag       = 4'h0;
		exp_pc        = '0;
		errors        = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		seed          = 32'h4bb0;
		for (int i = 0; i < 256; i++)
			mem[i] = $random(seed);
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		reset_and_sequence();
		freeze_replay();
		error_tags();
		flush_bypass();
		redirect_load();
		dslot_rfe_kill();
		$display("Summary: %0d tests passed, %0d tests failed, %0d checks failed",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* verilog/fetch_bus_pkg.sv */
////////////////////////////////////////////////////////////
// Instruction cache port types
// Request from the PC generator, response into fetch
////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

package fetch_bus_pkg;

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	// Fetch request, held for as long as the address is wanted
	typedef struct packed {
		// Word address, bit 0 marks the first fetch after a redirect
		logic [`FETCH_AW-1:0] adr;
		// Request active
		logic                 cyc;
	} ic_req_t;

	////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////

	// Cache answer, ack or err qualifies the whole struct
	typedef struct packed {
		logic [`FETCH_DW-1:0]   dat;
		logic                   ack;
		logic                   err;
		// Address echoed back with the word
		logic [`FETCH_AW-1:0]   adr;
		// Error cause when err is set
		logic [`FETCH_TAGW-1:0] tag;
	} ic_rsp_t;

endpackage

/* verilog/fetch_defines.svh */
////////////////////////////////////////////////////////////
// Fetch front end constants
// Widths, reset vector, no-op bubble words and the
// instruction cache error tag codes
////////////////////////////////////////////////////////////

`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Datapath widths
`define FETCH_AW 32
`define FETCH_DW 32
`define FETCH_TAGW 4

// First fetch address out of reset
`define FETCH_RESET_VECTOR 32'h0000_0100

// No-op major opcode
`define FETCH_NOP_OPC 6'b000101

// Bubble for flush, bypass and end of delay slots
`define FETCH_NOP_FLUSH {`FETCH_NOP_OPC, 26'h041_0000}

// Bubble while waiting on the cache
`define FETCH_NOP_STALL {`FETCH_NOP_OPC, 26'h061_0000}

////////////////////////////////////////////////////////////
// Cache error tags, valid together with err
////////////////////////////////////////////////////////////

// TLB miss
`define FETCH_TAG_TE 4'hd
// Page fault
`define FETCH_TAG_PE 4'hc
// Bus error
`define FETCH_TAG_BE 4'hb

`endif

/* verilog/fetch_pipe_pkg.sv */
////////////////////////////////////////////////////////////
// Pipeline side types of the fetch front end
// Output to decode and redirect from branch and exceptions
////////////////////////////////////////////////////////////

`include "fetch_defines.svh"

package fetch_pipe_pkg;

	// Fetch exceptions, at most one set per word
	typedef struct packed {
		logic itlbmiss;
		logic immufault;
		logic ibuserr;
	} fetch_exc_t;

	////////////////////////////////////////////////////////////
	// Toward decode
	////////////////////////////////////////////////////////////

	// Word handed to decode with its address and flags
	typedef struct packed {
		logic [`FETCH_DW-1:0] insn;
		logic [`FETCH_AW-1:0] pc;
		fetch_exc_t           exc;
	} fetch_out_t;

	////////////////////////////////////////////////////////////
	// From branch unit and exception unit
	////////////////////////////////////////////////////////////

	// One cycle strobe with the new fetch address
	typedef struct packed {
		logic                 valid;
		logic [`FETCH_AW-1:0] target;
	} redirect_t;

endpackage

/* verilog/fetch_top.sv */
////////////////////////////////////////////////////////////
// Fetch front end top level
// Joins the PC generator and the fetch stage
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_top
	import fetch_bus_pkg::*;
	import fetch_pipe_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	// Instruction cache port
	input  ic_rsp_t    ic_rsp_i,
	output ic_req_t    ic_req_o,
	// Pipeline control
	input  logic       freeze_i,
	input  logic       flushpipe_i,
	input  logic       no_more_dslot_i,
	input  logic       rfe_i,
	input  redirect_t  redirect_i,
	// Toward decode
	output fetch_out_t fetch_o,
	output logic       if_stall_o,
	output logic       saving_insn_o
);

	// Fetch stage back to PC generator
	logic                 refetch;
	logic [`FETCH_AW-1:0] saved_pc;

	////////////////////////////////////////////////////////////
	// Address side
	////////////////////////////////////////////////////////////

	pc_gen u_pc_gen (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.freeze_i   (freeze_i),
		.if_stall_i (if_stall_o),
		.refetch_i  (refetch),
		.saved_pc_i (saved_pc),
		.redirect_i (redirect_i),
		.ic_req_o   (ic_req_o)
	);

	////////////////////////////////////////////////////////////
	// Data side
	////////////////////////////////////////////////////////////

	insn_fetch u_insn_fetch (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.ic_rsp_i        (ic_rsp_i),
		.freeze_i        (freeze_i),
		.flushpipe_i     (flushpipe_i),
		.no_more_dslot_i (no_more_dslot_i),
		.rfe_i           (rfe_i),
		.fetch_o         (fetch_o),
		.saving_insn_o   (saving_insn_o),
		.if_stall_o      (if_stall_o),
		.refetch_o       (refetch),
		.saved_pc_o      (saved_pc)
	);

endmodule

/* verilog/insn_fetch.sv */
////////////////////////////////////////////////////////////
// Instruction fetch stage
// Presents word, address and fetch exceptions to decode,
// holds one word under freeze and inserts no-op bubbles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module insn_fetch
	import fetch_bus_pkg::*;
	import fetch_pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n_i,
	// Cache response
	input  ic_rsp_t              ic_rsp_i,
	// Pipeline control
	input  logic                 freeze_i,
	input  logic                 flushpipe_i,
	input  logic                 no_more_dslot_i,
	input  logic                 rfe_i,
	// Toward decode
	output fetch_out_t           fetch_o,
	output logic                 saving_insn_o,
	output logic                 if_stall_o,
	// Toward the PC generator
	output logic                 refetch_o,
	output logic [`FETCH_AW-1:0] saved_pc_o
);

	localparam int AW = `FETCH_AW;
	localparam int DW = `FETCH_DW;

	logic          save_insn;
	logic          bypass;
	logic          bypass_q;
	logic          kill;
	logic          saved_q;
	logic [DW-1:0] insn_saved_q;
	logic [AW-1:0] addr_saved_q;
	logic [AW-1:0] rsp_adr_al;
	fetch_exc_t    exc_saved_q;
	fetch_exc_t    exc_live;

	// Word aligned view of the echoed address
	assign rsp_adr_al = {ic_rsp_i.adr[AW-1:2], 2'b00};

	// Capture a response that lands while frozen, one deep
	assign save_insn     = (ic_rsp_i.ack | ic_rsp_i.err) & freeze_i & !saved_q;
	assign saving_insn_o = save_insn & !flushpipe_i;

	// Delay slots exhausted or return from exception
	assign kill = no_more_dslot_i | rfe_i;

	// Error tag decode
	always_comb begin
		exc_live.itlbmiss  = ic_rsp_i.err & (ic_rsp_i.tag == `FETCH_TAG_TE);
		exc_live.immufault = ic_rsp_i.err & (ic_rsp_i.tag == `FETCH_TAG_PE);
		exc_live.ibuserr   = ic_rsp_i.err & (ic_rsp_i.tag == `FETCH_TAG_BE);
	end

	////////////////////////////////////////////////////////////
	// Bypass after flush
	////////////////////////////////////////////////////////////

	// Bubble from the cycle after flush up to a marked address
	assign bypass = bypass_q & !ic_rsp_i.adr[0];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			bypass_q <= 1'b0;
		else
			bypass_q <= flushpipe_i | bypass;
	end

	////////////////////////////////////////////////////////////
	// Saved word state
	////////////////////////////////////////////////////////////

	// Flag and error bits, flush beats save beats release
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			saved_q     <= 1'b0;
			exc_saved_q <= '0;
		end else if (flushpipe_i) begin
			saved_q     <= 1'b0;
			exc_saved_q <= '0;
		end else if (save_insn) begin
			saved_q     <= 1'b1;
			exc_saved_q <= exc_live;
		end else if (!freeze_i) begin
			saved_q     <= 1'b0;
			exc_saved_q <= '0;
		end
	end

	// Word and address, only looked at while saved_q is set
	always_ff @(posedge clk) begin
		if (flushpipe_i) begin
			insn_saved_q <= `FETCH_NOP_FLUSH;
			addr_saved_q <= '0;
		end else if (save_insn) begin
			// An errored fetch replays as a bubble
			insn_saved_q <= ic_rsp_i.err ? `FETCH_NOP_FLUSH : ic_rsp_i.dat;
			addr_saved_q <= rsp_adr_al;
		end else if (!freeze_i) begin
			insn_saved_q <= `FETCH_NOP_FLUSH;
			addr_saved_q <= rsp_adr_al;
		end
	end

	////////////////////////////////////////////////////////////
	// Output to decode
	////////////////////////////////////////////////////////////

	always_comb begin
		if (kill || bypass)
			fetch_o.insn = `FETCH_NOP_FLUSH;
		else if (saved_q)
			fetch_o.insn = insn_saved_q;
		else if (ic_rsp_i.ack)
			fetch_o.insn = ic_rsp_i.dat;
		else if (ic_rsp_i.err)
			fetch_o.insn = `FETCH_NOP_FLUSH;
		else
			fetch_o.insn = `FETCH_NOP_STALL;
		fetch_o.pc  = saved_q ? addr_saved_q : rsp_adr_al;
		// Killed slots never raise an exception
		fetch_o.exc = kill ? '0 : (saved_q ? exc_saved_q : exc_live);
	end

	// Nothing to decode until the cache answers or a word is held
	assign if_stall_o = !ic_rsp_i.err & !ic_rsp_i.ack & !saved_q;
	// Late ack while replaying, PC restarts after the saved word
	assign refetch_o  = saved_q & ic_rsp_i.ack;
	assign saved_pc_o = addr_saved_q;

	a_save_sets_flag: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		saving_insn_o |=> saved_q
	);

	a_dslot_no_exc: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		no_more_dslot_i |-> (fetch_o.exc == '0)
	);

	a_flush_clears_saved: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		flushpipe_i |=> !saved_q
	);

endmodule

/* verilog/pc_gen.sv */
////////////////////////////////////////////////////////////
// Program counter generator
// Picks the next fetch address and drives the cache request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "fetch_defines.svh"

module pc_gen
	import fetch_bus_pkg::*;
	import fetch_pipe_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n_i,
	// Pipeline hold and cache wait
	input  logic                 freeze_i,
	input  logic                 if_stall_i,
	// Resume after a replayed word
	input  logic                 refetch_i,
	input  logic [`FETCH_AW-1:0] saved_pc_i,
	// Branch or exception target
	input  redirect_t            redirect_i,
	output ic_req_t              ic_req_o
);

	localparam int AW = `FETCH_AW;
	localparam logic [AW-1:0] PC_STEP = AW'(4);

	logic [AW-1:0] pc_q;
	logic [AW-1:0] pc_d;
	// Set while the redirect target is still on the bus
	logic          mark_q;
	logic          mark_d;

	////////////////////////////////////////////////////////////
	// Next address selection
	////////////////////////////////////////////////////////////

	always_comb begin
		pc_d   = pc_q;
		mark_d = mark_q;
		if (redirect_i.valid) begin
			// Redirect wins over everything, word aligned
			pc_d   = {redirect_i.target[AW-1:2], 2'b00};
			mark_d = 1'b1;
		end else if (refetch_i) begin
			// Word after the replayed one
			pc_d   = saved_pc_i + PC_STEP;
			mark_d = 1'b0;
		end else if (!freeze_i && !if_stall_i) begin
			pc_d   = pc_q + PC_STEP;
			mark_d = 1'b0;
		end
	end

	// PC register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q   <= `FETCH_RESET_VECTOR;
			mark_q <= 1'b0;
		end else begin
			pc_q   <= pc_d;
			mark_q <= mark_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Cache request
	////////////////////////////////////////////////////////////

	always_comb begin
		// Bit 0 tells fetch that the bypass bubble may end
		ic_req_o.adr = pc_q | {{(AW-1){1'b0}}, mark_q};
		// Fetch runs without pause, a hold re-presents the address
		ic_req_o.cyc = 1'b1;
	end

	// Target reaches the bus one cycle after the strobe
	a_redirect_to_req: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		redirect_i.valid |=>
			(ic_req_o.adr[AW-1:2] == $past(redirect_i.target[AW-1:2])) && ic_req_o.adr[0]
	);

endmodule
